//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////
    localparam int addr_width  = 32;
    localparam int way_bits    = 2;
    localparam int ways        = 1 << way_bits;
    localparam int index_bits  = 7;
    localparam int sets        = 1 << index_bits;
    localparam int offset_bits = 2;
    localparam int tag_bits    = addr_width - index_bits - offset_bits;

    typedef logic [addr_width-1:0]  addr_t;
    typedef logic [31:0]            word_t;
    typedef logic [way_bits-1:0]    way_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [tag_bits-1:0]    tag_t;

    // byte address split into its fields
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef struct packed {
        logic         wr;
        access_size_e size;
        addr_t        addr;
        word_t        wdata;
    } cpu_req_t;

    // always a full word on the memory side
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_refill    = 2'd1,
        st_writeback = 2'd2
    } miss_state_e;

    typedef struct packed {
        logic  hit;
        way_t  way;
        word_t rdata;
        logic  victim_valid;
        logic  victim_dirty;
        tag_t  victim_tag;
        word_t victim_data;
    } lookup_t;

endpackage

`default_nettype wire

//--- source/dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lru
    import dcache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire index_t index,
    input  wire logic   touch,
    input  wire way_t   touch_way,
    output way_t        victim
);

    // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
    logic [2:0] tree_q [sets];
    logic [2:0] cur_tree;

    assign cur_tree = tree_q[index];

    // root picks the pair, leaf picks the way in it
    assign victim = cur_tree[0] ? {1'b1, cur_tree[2]} : {1'b0, cur_tree[1]};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int s = 0; s < sets; s++)
                tree_q[s] <= 3'b000;
        end
        else if (touch)
        begin
            tree_q[index][0] <= ~touch_way[1];     // point at the other pair
            if (touch_way[1])
                tree_q[index][2] <= ~touch_way[0];
            else
                tree_q[index][1] <= ~touch_way[0];
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_store
    import dcache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,

    // lookup side
    input  wire index_t lookup_index,
    input  wire tag_t   lookup_tag,
    input  wire way_t   victim_way,
    output lookup_t     lookup,

    // single write port
    input  wire logic   wr_en,
    input  wire index_t wr_index,
    input  wire way_t   wr_way,
    input  wire tag_t   wr_tag,
    input  wire word_t  wr_data,
    input  wire logic   wr_dirty
);

    ////////////////////////////////////////
    // line state and payload
    ////////////////////////////////////////
    logic [ways-1:0] valid_q [sets];
    logic [ways-1:0] dirty_q [sets];
    tag_t            tag_q   [sets][ways];
    word_t           data_q  [sets][ways];

    logic [ways-1:0] hit_vec;
    way_t            hit_way;

    ////////////////////////////////////////
    // hit detection
    ////////////////////////////////////////
    always_comb
    begin
        for (int w = 0; w < ways; w++)
            hit_vec[w] = valid_q[lookup_index][w] && (tag_q[lookup_index][w] == lookup_tag);
    end

    // at most one way can match
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < ways; w++)
        begin
            if (hit_vec[w])
                hit_way = way_t'(w);
        end
    end

    always_comb
    begin
        lookup.hit          = |hit_vec;
        lookup.way          = hit_way;
        lookup.rdata        = data_q[lookup_index][hit_way];
        lookup.victim_valid = valid_q[lookup_index][victim_way];
        lookup.victim_dirty = dirty_q[lookup_index][victim_way];
        lookup.victim_tag   = tag_q[lookup_index][victim_way];
        lookup.victim_data  = data_q[lookup_index][victim_way];
    end

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int s = 0; s < sets; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (wr_en)
        begin
            valid_q[wr_index][wr_way] <= 1'b1;
            dirty_q[wr_index][wr_way] <= wr_dirty;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_q[wr_index][wr_way]  <= wr_tag;
            data_q[wr_index][wr_way] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    // processor side
    input  wire logic     cpu_req,
    input  wire cpu_req_t cpu_in,
    output word_t         cpu_rdata,
    output logic          cpu_addr_ok,
    output logic          cpu_data_ok,

    // store and lru
    input  wire lookup_t  lookup,
    input  wire way_t     lru_victim,
    output logic          touch,
    output way_t          touch_way,
    output logic          wr_en,
    output index_t        wr_index,
    output way_t          wr_way,
    output tag_t          wr_tag,
    output word_t         wr_data,
    output logic          wr_dirty,

    // memory side
    output logic          mem_req,
    output mem_req_t      mem_out,
    input  wire word_t    mem_rdata,
    input  wire logic     mem_addr_ok,
    input  wire logic     mem_data_ok
);

    miss_state_e  state_q;
    miss_state_e  state_d;
    addr_fields_t req_addr;
    logic [3:0]   byte_mask;
    word_t        hit_merge;
    word_t        fill_data;
    logic         hit_ok;
    logic         refill_done;
    logic         victim_dirty;
    logic         mem_sent_q;    // address accepted, waiting for data_ok
    word_t        wb_data_q;
    addr_t        wb_addr_q;

    function automatic word_t merge_lanes(word_t old_word, word_t new_word, logic [3:0] mask);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (mask[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    assign req_addr = addr_fields_t'(cpu_in.addr);

    always_comb
    begin
        case (cpu_in.size)
            size_byte: byte_mask = 4'b0001 << req_addr.offset;
            size_half: byte_mask = 4'b0011 << req_addr.offset;
            default:   byte_mask = 4'b1111;
        endcase
    end

    assign hit_merge = merge_lanes(lookup.rdata, cpu_in.wdata, byte_mask);
    assign fill_data = cpu_in.wr ? merge_lanes(mem_rdata, cpu_in.wdata, byte_mask) : mem_rdata;

    assign hit_ok       = cpu_req && lookup.hit && (state_q != st_refill);
    assign refill_done  = (state_q == st_refill) && mem_data_ok;
    assign victim_dirty = lookup.victim_valid && lookup.victim_dirty;

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:
                if (cpu_req && !lookup.hit)
                    state_d = st_refill;
            st_refill:
                if (mem_data_ok)
                    state_d = victim_dirty ? st_writeback : st_idle;
            st_writeback:
                if (mem_data_ok)
                    state_d = (cpu_req && !lookup.hit) ? st_refill : st_idle;
            default:
                state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q    <= st_idle;
            mem_sent_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (mem_data_ok)
                mem_sent_q <= 1'b0;
            else if (mem_req && mem_addr_ok)
                mem_sent_q <= 1'b1;
        end
    end

    // dirty victim leaves the arrays when the refill lands
    always_ff @(posedge clk)
    begin
        if (refill_done && victim_dirty)
        begin
            wb_data_q <= lookup.victim_data;
            wb_addr_q <= {lookup.victim_tag, req_addr.index, {offset_bits{1'b0}}};
        end
    end

    ////////////////////////////////////////
    // store write port and lru touch
    ////////////////////////////////////////
    always_comb
    begin
        wr_en    = 1'b0;
        wr_way   = lookup.way;
        wr_data  = hit_merge;
        wr_dirty = 1'b1;
        if (refill_done)
        begin
            wr_en    = 1'b1;
            wr_way   = lru_victim;
            wr_data  = fill_data;
            wr_dirty = cpu_in.wr;    // read fills stay clean
        end
        else if (hit_ok && cpu_in.wr)
            wr_en = 1'b1;
    end

    assign wr_index  = req_addr.index;
    assign wr_tag    = req_addr.tag;
    assign touch     = hit_ok || refill_done;
    assign touch_way = refill_done ? lru_victim : lookup.way;

    // processor response
    assign cpu_addr_ok = hit_ok || refill_done;
    assign cpu_data_ok = hit_ok || refill_done;
    assign cpu_rdata   = hit_ok ? lookup.rdata : mem_rdata;

    // memory request
    assign mem_req       = (state_q != st_idle) && !mem_sent_q;
    assign mem_out.wr    = (state_q == st_writeback);
    assign mem_out.addr  = mem_out.wr ? wb_addr_q
                                      : {cpu_in.addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    assign mem_out.wdata = wb_data_q;

endmodule

`default_nettype wire

//--- source/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     cpu_req,
    input  wire cpu_req_t cpu_in,
    output word_t         cpu_rdata,
    output logic          cpu_addr_ok,
    output logic          cpu_data_ok,
    output logic          mem_req,
    output mem_req_t      mem_out,
    input  wire word_t    mem_rdata,
    input  wire logic     mem_addr_ok,
    input  wire logic     mem_data_ok
);

    addr_fields_t req_addr;
    lookup_t      lookup;
    way_t         lru_victim;
    logic         touch;
    way_t         touch_way;
    logic         wr_en;
    index_t       wr_index;
    way_t         wr_way;
    tag_t         wr_tag;
    word_t        wr_data;
    logic         wr_dirty;

    assign req_addr = addr_fields_t'(cpu_in.addr);

    dcache_store store0 (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (req_addr.index),
        .lookup_tag   (req_addr.tag),
        .victim_way   (lru_victim),
        .lookup       (lookup),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_way       (wr_way),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .wr_dirty     (wr_dirty)
    );

    dcache_lru lru0 (
        .clk       (clk),
        .rst       (rst),
        .index     (req_addr.index),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (lru_victim)
    );

    dcache_miss_ctrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_in      (cpu_in),
        .cpu_rdata   (cpu_rdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .lookup      (lookup),
        .lru_victim  (lru_victim),
        .touch       (touch),
        .touch_way   (touch_way),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_way      (wr_way),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data),
        .wr_dirty    (wr_dirty),
        .mem_req     (mem_req),
        .mem_out     (mem_out),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

endmodule

`default_nettype wire

//--- verification/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     mem_req,
    input  wire mem_req_t mem_in,
    output word_t         mem_rdata,
    output logic          mem_addr_ok,
    output logic          mem_data_ok,
    input  wire addr_t    tap_addr,
    output word_t         tap_data
);

    word_t       mem [1024];    // 4 KiB of word storage
    logic [1:0]  phase_q;       // 0 idle, 1 addr_ok, 2 waiting, 3 data_ok
    logic [2:0]  wait_q;
    mem_req_t    held_q;
    logic [31:0] lcg_q;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every word gets a value derived from its full byte address
    initial
    begin
        for (int i = 0; i < 1024; i++)
            mem[i] = {16'(i * 4), 16'h0000} ^ 32'hc3a55a3c;
    end

    assign tap_data = mem[tap_addr[11:2]];

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase_q     <= 2'd0;
            wait_q      <= 3'd0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            lcg_q       <= 32'h9c37581a;
        end
        else
        begin
            case (phase_q)
                2'd0:
                    if (mem_req)
                    begin
                        held_q      <= mem_in;
                        mem_addr_ok <= 1'b1;
                        phase_q     <= 2'd1;
                        lcg_q       <= lcg_step(lcg_q);
                        wait_q      <= 3'(lcg_q[17:16]) + 3'd1;    // 1 to 4 cycles
                    end
                2'd1:
                begin
                    mem_addr_ok <= 1'b0;
                    phase_q     <= 2'd2;
                end
                2'd2:
                    if (wait_q == 3'd1)
                    begin
                        mem_data_ok <= 1'b1;
                        mem_rdata   <= mem[held_q.addr[11:2]];
                        if (held_q.wr)
                            mem[held_q.addr[11:2]] <= held_q.wdata;
                        phase_q <= 2'd3;
                    end
                    else
                        wait_q <= wait_q - 3'd1;
                default:
                begin
                    mem_data_ok <= 1'b0;
                    phase_q     <= 2'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     cpu_req;
    cpu_req_t cpu_in;
    word_t    cpu_rdata;
    logic     cpu_addr_ok;
    logic     cpu_data_ok;
    logic     mem_req;
    mem_req_t mem_out;
    word_t    mem_rdata;
    logic     mem_addr_ok;
    logic     mem_data_ok;
    addr_t    tap_addr;
    word_t    tap_data;

    logic [7:0]  ref_mem [4096];    // byte-wide reference memory
    logic        m_valid [sets][ways];
    logic        m_dirty [sets][ways];
    tag_t        m_tag   [sets][ways];
    logic [2:0]  m_tree  [sets];
    int          predicted_wb;
    int          seen_wb;
    addr_t       written_q [$];
    logic [31:0] rng;
    int          n_lines;
    logic        loaded;

    // file rows
    logic         f_wr   [$];
    access_size_e f_size [$];
    addr_t        f_addr [$];
    word_t        f_data [$];
    logic         f_chk  [$];
    word_t        f_exp  [$];

    dcache dut0 (.*);

    dcache_mem_model mem0 (
        .clk (clk), .rst (rst), .mem_req (mem_req), .mem_in (mem_out),
        .mem_rdata (mem_rdata), .mem_addr_ok (mem_addr_ok), .mem_data_ok (mem_data_ok),
        .tap_addr (tap_addr), .tap_data (tap_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] lane_mask(input access_size_e size, input logic [1:0] off);
        case (size)
            size_byte: return 4'b0001 << off;
            size_half: return 4'b0011 << off;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic word_t ref_word(input addr_t a);
        return {ref_mem[{a[11:2], 2'd3}], ref_mem[{a[11:2], 2'd2}],
                ref_mem[{a[11:2], 2'd1}], ref_mem[{a[11:2], 2'd0}]};
    endfunction

    function automatic word_t apply_mask(input word_t w, input logic [3:0] m);
        return w & {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL t=%0t: %s got %h expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // tree pseudo-LRU and dirty tracking, used to predict writebacks
    task automatic predict_lines(input logic wr, input addr_t a);
        addr_fields_t f;
        int           way;
        f   = addr_fields_t'(a);
        way = -1;
        for (int w = 0; w < ways; w++)
            if (m_valid[f.index][w] && m_tag[f.index][w] == f.tag)
                way = w;
        if (way < 0)
        begin
            way = m_tree[f.index][0] ? 2 + m_tree[f.index][2] : m_tree[f.index][1];
            if (m_valid[f.index][way] && m_dirty[f.index][way])
                predicted_wb++;
            m_valid[f.index][way] = 1'b1;
            m_tag[f.index][way]   = f.tag;
            m_dirty[f.index][way] = wr;
        end
        else if (wr)
            m_dirty[f.index][way] = 1'b1;
        m_tree[f.index][0] = ~way[1];
        if (way[1])
            m_tree[f.index][2] = ~way[0];
        else
            m_tree[f.index][1] = ~way[0];
    endtask

    task automatic run_access(input logic wr, input access_size_e size, input addr_t a,
                              input word_t wdata, input logic chk, input word_t exp);
        logic [3:0] m;
        word_t      rd;
        m          = lane_mask(size, a[1:0]);
        cpu_req    = 1'b1;
        cpu_in.wr  = wr;
        cpu_in.size  = size;
        cpu_in.addr  = a;
        cpu_in.wdata = wdata;
        do
        begin
            @(negedge clk);
            check_equal(cpu_addr_ok, cpu_data_ok, "addr_ok vs data_ok");
        end
        while (!cpu_data_ok);
        rd = cpu_rdata;
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
        predict_lines(wr, a);
        if (wr)
        begin
            for (int b = 0; b < 4; b++)
                if (m[b])
                    ref_mem[{a[11:2], 2'(b)}] = wdata[b*8 +: 8];
            written_q.push_back({a[31:2], 2'b00});
        end
        else
        begin
            check_equal(apply_mask(rd, m), apply_mask(ref_word(a), m), "read vs reference");
            if (chk)
                check_equal(apply_mask(rd, m), apply_mask(exp, m), "read vs file");
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        string       line;
        logic [7:0]  op_c;
        logic [7:0]  size_c;
        addr_t       a;
        word_t       d;
        int          c;
        word_t       e;
        fd = $fopen("verification/dcache_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file");
            $display("CHECKS FAILED");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%s %s %h %h %d %h", op_c, size_c, a, d, c, e) == 6)
            begin
                f_wr.push_back(op_c == "w");
                f_size.push_back(size_c == "b" ? size_byte : size_c == "h" ? size_half : size_word);
                f_addr.push_back(a);
                f_data.push_back(d);
                f_chk.push_back(c != 0);
                f_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // 40 cycles per access: file lines, sweep, readback
    initial
    begin
        wait (loaded);
        #((n_lines + 600) * 40 * 8 + 1000);
        $display("simulation hung: the watchdog ran out before the tests finished");
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    always @(negedge clk)
        if (mem_req && mem_addr_ok && mem_out.wr)
            seen_wb++;

    initial
    begin
        addr_t        a;
        access_size_e sz;
        addr_fields_t f;
        logic         cached_dirty;
        rst = 1'b1;
        cpu_req = 1'b0;
        cpu_in = '0;
        tap_addr = '0;
        loaded = 1'b0;
        predicted_wb = 0;
        seen_wb = 0;
        rng = 32'h9c37581a;
        for (int i = 0; i < 1024; i++)
            {ref_mem[i*4+3], ref_mem[i*4+2], ref_mem[i*4+1], ref_mem[i*4]} =
                {16'(i * 4), 16'h0000} ^ 32'hc3a55a3c;
        for (int s = 0; s < sets; s++)
        begin
            m_tree[s] = 3'b000;
            for (int w = 0; w < ways; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        load_stimulus();
        n_lines = f_wr.size();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        ////////////////////////////////////////
        // directed accesses from the file
        for (int i = 0; i < n_lines; i++)
            run_access(f_wr[i], f_size[i], f_addr[i], f_data[i], f_chk[i], f_exp[i]);

        ////////////////////////////////////////
        // random sweep over 2 KiB
        for (int i = 0; i < 300; i++)
        begin
            rng = lcg_step(rng);
            sz  = access_size_e'(rng[25:24] == 2'd3 ? 2'd2 : rng[25:24]);
            a   = {21'd0, rng[10:0]};
            if (sz == size_half)
                a[0] = 1'b0;
            else if (sz == size_word)
                a[1:0] = 2'b00;
            rng = lcg_step(rng);
            run_access(rng[28], sz, a, rng, 1'b0, '0);
        end
        foreach (written_q[i])
            run_access(1'b0, size_word, written_q[i], '0, 1'b0, '0);

        // let the last writeback finish
        for (int i = 0; i < 50 && seen_wb < predicted_wb; i++)
            @(posedge clk);
        repeat (10) @(posedge clk);
        check_equal(seen_wb, predicted_wb, "memory write count");

        // evicted dirty words must now sit in memory
        foreach (written_q[i])
        begin
            f = addr_fields_t'(written_q[i]);
            cached_dirty = 1'b0;
            for (int w = 0; w < ways; w++)
                if (m_valid[f.index][w] && m_tag[f.index][w] == f.tag && m_dirty[f.index][w])
                    cached_dirty = 1'b1;
            if (!cached_dirty)
            begin
                tap_addr = written_q[i];
                #1;
                check_equal(tap_data, ref_word(written_q[i]), "memory contents");
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
source/dcache_pkg.sv
source/dcache_lru.sv
source/dcache_store.sv
source/dcache_miss_ctrl.sv
source/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/dcache_lru.sv
  - source/dcache_store.sv
  - source/dcache_miss_ctrl.sv
  - source/dcache.sv
  - target: simulation
    files:
      - verification/dcache_mem_model.sv
      - verification/dcache_tb.sv

//--- verification/dcache_stimulus.txt
# op(r/w) size(b/h/w) addr(hex) wdata(hex, lane aligned) check(0/1) expected(hex)
# five tags in set 5 force an eviction, then read back
w w 00000014 11223344 0 00000000
w b 00000215 0000aa00 0 00000000
w h 00000416 beef0000 0 00000000
w w 00000614 55667788 0 00000000
w w 00000814 99aabbcc 0 00000000
r w 00000214 00000000 1 c1b1aa3c
r w 00000414 00000000 1 beef5a3c
r w 00000014 00000000 1 11223344
r b 00000017 00000000 1 11000000
r w 00000814 00000000 1 99aabbcc
r w 00000020 00000000 1 c3855a3c
